//--- common/riscv_defs.svh
`ifndef RISCV_DEFS_SVH
`define RISCV_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// datapath widths
// ~~~~~~~~~~~~~~~~~~~~
`define DATA_WIDTH        32
`define REG_ADDR_WIDTH    5
`define SHAMT_WIDTH       5   // shift amount taken from the low bits of operand b
`define OPCODE_WIDTH      7

// ~~~~~~~~~~~~~~~~~~~~
// control field widths
// ~~~~~~~~~~~~~~~~~~~~
`define ALU_OPT_WIDTH     4
`define SRC_SEL_WIDTH     2
`define FUNC_CODE_WIDTH   3

// ~~~~~~~~~~~~~~~~~~~~
// operand pair codes for the ALU inputs
// ~~~~~~~~~~~~~~~~~~~~
`define SRC_SEL_RS1_2     2'b00  // a = rs1, b = rs2
`define SRC_SEL_RS1_IMM   2'b01  // a = rs1, b = imm
`define SRC_SEL_PC_4      2'b10  // link address for jal and jalr
`define SRC_SEL_PC_IMM    2'b11  // auipc

`endif

//--- common/riscv_pkg.sv
`include "riscv_defs.svh"

package riscv_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // alu operations
  // ~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [`ALU_OPT_WIDTH-1:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10  // lui writes the immediate straight through
  } alu_opt_e;

  // ~~~~~~~~~~~~~~~~~~~~
  // instruction word views
  // ~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic [6:0]                  funct7;
    logic [`REG_ADDR_WIDTH-1:0]  rs2;
    logic [`REG_ADDR_WIDTH-1:0]  rs1;
    logic [`FUNC_CODE_WIDTH-1:0] funct3;
    logic [`REG_ADDR_WIDTH-1:0]  rd;
    logic [`OPCODE_WIDTH-1:0]    opcode;
  } inst_r_t;

  // immediate bits split at the boundaries shared by the S, B, U and J formats
  typedef struct packed {
    logic                      imm_31;
    logic [5:0]                imm_30_25;
    logic [3:0]                imm_24_21;
    logic                      imm_20;
    logic [7:0]                imm_19_12;
    logic [3:0]                imm_11_8;
    logic                      imm_7;
    logic [`OPCODE_WIDTH-1:0]  opcode;
  } inst_imm_t;

  typedef union packed {
    inst_r_t   r;
    inst_imm_t f;
  } inst_u;

  typedef struct packed {
    alu_opt_e                    alu_opt;
    logic [`SRC_SEL_WIDTH-1:0]   src_sel;
    logic [`FUNC_CODE_WIDTH-1:0] func_code;
    logic                        branch;
    logic                        jump;
    logic                        jump_reg;  // jalr, target is based on rs1
    logic                        reg_wen;
  } exu_ctrl_t;

  typedef struct packed {
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic                       reg_wen;
    logic [`DATA_WIDTH-1:0]     result;
    logic                       taken;
    logic [`DATA_WIDTH-1:0]     next_pc;
    logic [`DATA_WIDTH-1:0]     pc;
  } exu_res_t;

endpackage

//--- exu/riscv_ex_alu.sv
`timescale 1ns/1ns
`include "riscv_defs.svh"

module riscv_ex_alu (
  input  riscv_pkg::alu_opt_e    alu_opt,
  input  logic [`DATA_WIDTH-1:0] alu_a_data,
  input  logic [`DATA_WIDTH-1:0] alu_b_data,
  output logic                   carry_flag,
  output logic [`DATA_WIDTH-1:0] alu_out_data
);
  import riscv_pkg::*;

  logic [`DATA_WIDTH:0]       sub_full;
  logic [`DATA_WIDTH-1:0]     diff;
  logic [`DATA_WIDTH-1:0]     sum;
  logic [`SHAMT_WIDTH-1:0]    shamt;
  logic                       overflow;
  logic                       lt_signed;

  // ~~~~~~~~~~~~~~~~~~~~
  // adder and compare
  // ~~~~~~~~~~~~~~~~~~~~
  assign sum      = alu_a_data + alu_b_data;
  assign sub_full = {1'b0, alu_a_data} - {1'b0, alu_b_data};
  assign diff     = sub_full[`DATA_WIDTH-1:0];

  // borrow out of the top bit, set when a is below b unsigned
  assign carry_flag = sub_full[`DATA_WIDTH];

  assign overflow = (alu_a_data[`DATA_WIDTH-1] ^ alu_b_data[`DATA_WIDTH-1]) &
                    (alu_a_data[`DATA_WIDTH-1] ^ diff[`DATA_WIDTH-1]);
  assign lt_signed = diff[`DATA_WIDTH-1] ^ overflow;

  assign shamt = alu_b_data[`SHAMT_WIDTH-1:0];  // larger amounts wrap to 5 bits

  always_comb begin
    case (alu_opt)
      ALU_ADD:    alu_out_data = sum;
      ALU_SUB:    alu_out_data = diff;
      ALU_SLL:    alu_out_data = alu_a_data << shamt;
      ALU_SLT:    alu_out_data = {{(`DATA_WIDTH-1){1'b0}}, lt_signed};
      ALU_SLTU:   alu_out_data = {{(`DATA_WIDTH-1){1'b0}}, carry_flag};
      ALU_XOR:    alu_out_data = alu_a_data ^ alu_b_data;
      ALU_SRL:    alu_out_data = alu_a_data >> shamt;
      ALU_SRA:    alu_out_data = $unsigned($signed(alu_a_data) >>> shamt);
      ALU_OR:     alu_out_data = alu_a_data | alu_b_data;
      ALU_AND:    alu_out_data = alu_a_data & alu_b_data;
      ALU_PASS_B: alu_out_data = alu_b_data;
      default:    alu_out_data = '0;
    endcase
  end

endmodule

//--- exu/riscv_exu.sv
`timescale 1ns/1ns
`include "riscv_defs.svh"

module riscv_exu (
  input  logic [`DATA_WIDTH-1:0] pc,
  input  logic [`DATA_WIDTH-1:0] src1,
  input  logic [`DATA_WIDTH-1:0] src2,
  input  logic [`DATA_WIDTH-1:0] imm,
  input  riscv_pkg::exu_ctrl_t   ctrl,
  output logic                   zero_flag,
  output logic [`DATA_WIDTH-1:0] exu_result
);

  logic [`DATA_WIDTH-1:0] alu_a_data;
  logic [`DATA_WIDTH-1:0] alu_b_data;
  logic [`DATA_WIDTH-1:0] alu_out_data;
  logic                   carry_flag;
  logic                   alu_zero;
  logic                   lt_signed;
  logic                   branch_cond;

  // ~~~~~~~~~~~~~~~~~~~~
  // operand selection
  // ~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    case (ctrl.src_sel)
      `SRC_SEL_RS1_2:   {alu_a_data, alu_b_data} = {src1, src2};
      `SRC_SEL_RS1_IMM: {alu_a_data, alu_b_data} = {src1, imm};
      `SRC_SEL_PC_4:    {alu_a_data, alu_b_data} = {pc, `DATA_WIDTH'd4};
      `SRC_SEL_PC_IMM:  {alu_a_data, alu_b_data} = {pc, imm};
      default:          {alu_a_data, alu_b_data} = '0;
    endcase
  end

  riscv_ex_alu u_alu (
    .alu_opt      (ctrl.alu_opt),
    .alu_a_data   (alu_a_data),
    .alu_b_data   (alu_b_data),
    .carry_flag   (carry_flag),
    .alu_out_data (alu_out_data)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // branch condition
  // ~~~~~~~~~~~~~~~~~~~~
  assign alu_zero = ~(|alu_out_data);  // difference is zero when rs1 equals rs2

  // on a sign mismatch the difference can overflow and a's sign decides instead
  assign lt_signed = (alu_a_data[`DATA_WIDTH-1] != alu_b_data[`DATA_WIDTH-1]) ?
                     alu_a_data[`DATA_WIDTH-1] : alu_out_data[`DATA_WIDTH-1];

  always_comb begin
    case (ctrl.func_code)
      3'b000:  branch_cond = alu_zero;     // beq
      3'b001:  branch_cond = ~alu_zero;    // bne
      3'b100:  branch_cond = lt_signed;    // blt
      3'b101:  branch_cond = ~lt_signed;   // bge
      3'b110:  branch_cond = carry_flag;   // bltu
      3'b111:  branch_cond = ~carry_flag;  // bgeu
      default: branch_cond = 1'b0;
    endcase
  end

  assign exu_result = ctrl.branch ?
                      {{(`DATA_WIDTH-1){1'b0}}, branch_cond} : alu_out_data;

  assign zero_flag = ~(|exu_result);

endmodule

//--- logic/riscv_idu_decode.sv
`timescale 1ns/1ns
`include "riscv_defs.svh"

module riscv_idu_decode (
  input  riscv_pkg::inst_u             inst,
  output riscv_pkg::exu_ctrl_t         ctrl,
  output logic [`DATA_WIDTH-1:0]       imm
);
  import riscv_pkg::*;

  localparam logic [`OPCODE_WIDTH-1:0] OPC_OP     = 7'b0110011;
  localparam logic [`OPCODE_WIDTH-1:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [`OPCODE_WIDTH-1:0] OPC_LUI    = 7'b0110111;
  localparam logic [`OPCODE_WIDTH-1:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [`OPCODE_WIDTH-1:0] OPC_JAL    = 7'b1101111;
  localparam logic [`OPCODE_WIDTH-1:0] OPC_JALR   = 7'b1100111;
  localparam logic [`OPCODE_WIDTH-1:0] OPC_BRANCH = 7'b1100011;

  logic [`DATA_WIDTH-1:0] imm_i;
  logic [`DATA_WIDTH-1:0] imm_b;
  logic [`DATA_WIDTH-1:0] imm_u;
  logic [`DATA_WIDTH-1:0] imm_j;
  logic                   branch_ok;
  logic                   imm_alt;

  // shared by register and immediate ALU forms, alt picks sub or sra
  function automatic alu_opt_e alu_map(input logic [`FUNC_CODE_WIDTH-1:0] funct3,
                                       input logic alt);
    alu_opt_e op;
    case (funct3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // immediates
  // ~~~~~~~~~~~~~~~~~~~~
  assign imm_i = {{20{inst.r.funct7[6]}}, inst.r.funct7, inst.r.rs2};
  assign imm_b = {{20{inst.f.imm_31}}, inst.f.imm_7, inst.f.imm_30_25,
                  inst.f.imm_11_8, 1'b0};
  assign imm_u = {inst.f.imm_31, inst.f.imm_30_25, inst.f.imm_24_21, inst.f.imm_20,
                  inst.f.imm_19_12, 12'b0};
  assign imm_j = {{12{inst.f.imm_31}}, inst.f.imm_19_12, inst.f.imm_20,
                  inst.f.imm_30_25, inst.f.imm_24_21, 1'b0};

  // funct3 010 and 011 are not branch conditions
  assign branch_ok = (inst.r.funct3[2:1] != 2'b01);

  // only srai uses funct7, addi must never turn into a subtract
  assign imm_alt = (inst.r.funct3 == 3'b101) && inst.r.funct7[5];

  // ~~~~~~~~~~~~~~~~~~~~
  // control
  // ~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    ctrl           = '0;
    ctrl.alu_opt   = ALU_ADD;
    ctrl.src_sel   = `SRC_SEL_RS1_2;
    ctrl.func_code = inst.r.funct3;
    imm            = '0;

    case (inst.r.opcode)
      OPC_OP: begin
        ctrl.alu_opt = alu_map(inst.r.funct3, inst.r.funct7[5]);
        ctrl.reg_wen = 1'b1;
      end
      OPC_OP_IMM: begin
        ctrl.alu_opt = alu_map(inst.r.funct3, imm_alt);
        ctrl.src_sel = `SRC_SEL_RS1_IMM;
        ctrl.reg_wen = 1'b1;
        imm          = imm_i;
      end
      OPC_LUI: begin
        ctrl.alu_opt = ALU_PASS_B;
        ctrl.src_sel = `SRC_SEL_RS1_IMM;
        ctrl.reg_wen = 1'b1;
        imm          = imm_u;
      end
      OPC_AUIPC: begin
        ctrl.src_sel = `SRC_SEL_PC_IMM;
        ctrl.reg_wen = 1'b1;
        imm          = imm_u;
      end
      OPC_JAL: begin
        ctrl.src_sel = `SRC_SEL_PC_4;
        ctrl.jump    = 1'b1;
        ctrl.reg_wen = 1'b1;
        imm          = imm_j;
      end
      OPC_JALR: begin
        ctrl.src_sel  = `SRC_SEL_PC_4;
        ctrl.jump     = 1'b1;
        ctrl.jump_reg = 1'b1;
        ctrl.reg_wen  = 1'b1;
        imm           = imm_i;
      end
      OPC_BRANCH: begin
        ctrl.alu_opt = ALU_SUB;  // compare rs1 against rs2
        ctrl.branch  = branch_ok;
        imm          = imm_b;
      end
      default: begin
        // unknown opcode leaves everything off, so nothing is written
      end
    endcase
  end

endmodule

//--- logic/riscv_exu_stage.sv
`timescale 1ns/1ns
`include "riscv_defs.svh"

module riscv_exu_stage (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   inst_valid,
  input  riscv_pkg::inst_u       inst,
  input  logic [`DATA_WIDTH-1:0] pc,
  input  logic [`DATA_WIDTH-1:0] src1,
  input  logic [`DATA_WIDTH-1:0] src2,
  output logic                   res_valid,
  output riscv_pkg::exu_res_t    res
);
  import riscv_pkg::*;

  exu_ctrl_t              ctrl;
  exu_res_t               res_d;
  logic [`DATA_WIDTH-1:0] imm;
  logic [`DATA_WIDTH-1:0] exu_result;
  logic [`DATA_WIDTH-1:0] target_base;
  logic [`DATA_WIDTH-1:0] target_sum;
  logic [`DATA_WIDTH-1:0] target_pc;
  logic [`DATA_WIDTH-1:0] pc_plus4;
  logic                   zero_flag;
  logic                   branch_taken;
  logic                   redirect;

  riscv_idu_decode u_decode (
    .inst (inst),
    .ctrl (ctrl),
    .imm  (imm)
  );

  riscv_exu u_exu (
    .pc         (pc),
    .src1       (src1),
    .src2       (src2),
    .imm        (imm),
    .ctrl       (ctrl),
    .zero_flag  (zero_flag),
    .exu_result (exu_result)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // next pc
  // ~~~~~~~~~~~~~~~~~~~~
  // a branch result is a single condition bit, so a nonzero result means taken
  assign branch_taken = ctrl.branch & ~zero_flag;
  assign redirect     = ctrl.jump | branch_taken;

  assign target_base = ctrl.jump_reg ? src1 : pc;
  assign target_sum  = target_base + imm;
  assign target_pc   = ctrl.jump_reg ? {target_sum[`DATA_WIDTH-1:1], 1'b0} : target_sum;
  assign pc_plus4    = pc + `DATA_WIDTH'd4;

  always_comb begin
    res_d         = '0;
    res_d.rd      = inst.r.rd;
    res_d.reg_wen = ctrl.reg_wen;
    res_d.result  = exu_result;
    res_d.taken   = redirect;
    res_d.next_pc = redirect ? target_pc : pc_plus4;
    res_d.pc      = pc;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // result register
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_valid <= 1'b0;
      res       <= '0;
    end else begin
      res_valid <= inst_valid;  // one cycle after the strobe
      if (inst_valid) begin
        res <= res_d;
      end
    end
  end

endmodule

//--- verification/riscv_exu_stage_assertions.sv
`timescale 1ns/1ns
`include "riscv_defs.svh"

module riscv_exu_stage_assertions (
  input logic                   clk,
  input logic                   arst_n,
  input logic                   inst_valid,
  input riscv_pkg::inst_u       inst,
  input logic [`DATA_WIDTH-1:0] pc,
  input logic [`DATA_WIDTH-1:0] src1,
  input logic [`DATA_WIDTH-1:0] src2,
  input logic                   res_valid,
  input riscv_pkg::exu_res_t    res
);
  import riscv_pkg::*;

  logic [`DATA_WIDTH-1:0] w;
  logic [`DATA_WIDTH-1:0] imm_i;
  logic [`DATA_WIDTH-1:0] imm_b;
  logic [`DATA_WIDTH-1:0] imm_u;
  logic [`DATA_WIDTH-1:0] imm_j;
  exu_res_t               exp_d;
  exu_res_t               exp_q;
  logic                   known_d;  // result is only defined for supported opcodes
  logic                   known_q;
  logic                   valid_q;
  int                     fail_count = 0;

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~
  assign w     = inst;
  assign imm_i = {{20{w[31]}}, w[31:20]};
  assign imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
  assign imm_u = {w[31:12], 12'h000};
  assign imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};

  always_comb begin
    exp_d         = '0;
    exp_d.rd      = w[11:7];
    exp_d.pc      = pc;
    exp_d.next_pc = pc + 32'd4;
    known_d       = 1'b1;
    case (w[6:0])
      7'b0110011, 7'b0010011: begin  // register and immediate forms where only srai reads funct7
        exp_d.reg_wen = 1'b1;
        exp_d.result  = w[5] ? alu_ref(w[14:12], w[30], src1, src2) :
                               alu_ref(w[14:12], w[30] && w[14:12] == 3'd5, src1, imm_i);
      end
      7'b0110111, 7'b0010111: begin  // lui and auipc
        exp_d.reg_wen = 1'b1;
        exp_d.result  = w[5] ? imm_u : pc + imm_u;
      end
      7'b1101111, 7'b1100111: begin
        exp_d.reg_wen = 1'b1;
        exp_d.result  = pc + 32'd4;  // link address
        exp_d.taken   = 1'b1;
        exp_d.next_pc = w[3] ? pc + imm_j : (src1 + imm_i) & ~32'd1;
      end
      7'b1100011: begin
        exp_d.taken  = (w[14:13] != 2'b01) && branch_ref(w[14:12], src1, src2);
        exp_d.result = {31'b0, exp_d.taken};
        known_d      = (w[14:13] != 2'b01);
        if (exp_d.taken) begin
          exp_d.next_pc = pc + imm_b;
        end
      end
      default: known_d = 1'b0;  // unsupported opcode writes nothing
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
      exp_q   <= '0;
      known_q <= 1'b0;
    end else begin
      valid_q <= inst_valid;
      exp_q   <= exp_d;
      known_q <= known_d;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~
  a_reset: assert property (@(posedge clk) (!arst_n || $rose(arst_n)) |->
                            (!res_valid && res == '0))
    else begin
      fail_count++;
      $error("FAILED at %0t res_valid got %b expected 0 and res got %h expected 0", $time,
             $sampled(res_valid), $sampled(res));
    end

  a_valid: assert property (@(posedge clk) disable iff (!arst_n) res_valid == valid_q)
    else begin
      fail_count++;
      $error("FAILED at %0t res_valid got %b expected %b", $time,
             $sampled(res_valid), $sampled(valid_q));
    end

  a_result: assert property (@(posedge clk) disable iff (!arst_n)
                             (res_valid && known_q) |-> res.result == exp_q.result)
    else begin
      fail_count++;
      $error("FAILED at %0t res.result got %h expected %h", $time,
             $sampled(res.result), $sampled(exp_q.result));
    end

  a_next_pc: assert property (@(posedge clk) disable iff (!arst_n)
                              res_valid |-> res.next_pc == exp_q.next_pc)
    else begin
      fail_count++;
      $error("FAILED at %0t res.next_pc got %h expected %h", $time,
             $sampled(res.next_pc), $sampled(exp_q.next_pc));
    end

  a_taken: assert property (@(posedge clk) disable iff (!arst_n)
                            res_valid |-> res.taken == exp_q.taken)
    else begin
      fail_count++;
      $error("FAILED at %0t res.taken got %b expected %b", $time,
             $sampled(res.taken), $sampled(exp_q.taken));
    end

  a_reg_wen: assert property (@(posedge clk) disable iff (!arst_n)
                              res_valid |-> res.reg_wen == exp_q.reg_wen)
    else begin
      fail_count++;
      $error("FAILED at %0t res.reg_wen got %b expected %b", $time,
             $sampled(res.reg_wen), $sampled(exp_q.reg_wen));
    end

  a_rd: assert property (@(posedge clk) disable iff (!arst_n)
                         res_valid |-> res.rd == exp_q.rd)
    else begin
      fail_count++;
      $error("FAILED at %0t res.rd got %h expected %h", $time,
             $sampled(res.rd), $sampled(exp_q.rd));
    end

  a_pc: assert property (@(posedge clk) disable iff (!arst_n)
                         res_valid |-> res.pc == exp_q.pc)
    else begin
      fail_count++;
      $error("FAILED at %0t res.pc got %h expected %h", $time,
             $sampled(res.pc), $sampled(exp_q.pc));
    end

endmodule

bind riscv_exu_stage riscv_exu_stage_assertions u_assertions (
  .clk(clk), .arst_n(arst_n), .inst_valid(inst_valid), .inst(inst), .pc(pc),
  .src1(src1), .src2(src2), .res_valid(res_valid), .res(res)
);

//--- verification/riscv_exu_stage_tb.sv
`timescale 1ns/1ns
`include "riscv_defs.svh"

module riscv_exu_stage_tb;
  import riscv_pkg::*;

  localparam int ALU_N    = 40;
  localparam int BRANCH_N = 24;  // six conditions with four operand pairs each
  localparam int JUMP_N   = 16;
  localparam int UPPER_N  = 18;
  localparam int MIX_N    = 20;
  // reset, two idle cycles per test, one gap per strobe and random gaps of up to three
  localparam int STIM_CYCLES    = 3 + 6 * 2 + 2 * (ALU_N + BRANCH_N + JUMP_N + UPPER_N)
                                  + 5 * MIX_N;
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;
  localparam logic [6:0] MIX_OPS [4] = '{7'h33, 7'h13, 7'h37, 7'h6f};

  logic                   clk = 1'b0;
  logic                   arst_n;
  logic                   inst_valid;
  inst_u                  inst;
  logic [`DATA_WIDTH-1:0] pc;
  logic [`DATA_WIDTH-1:0] src1;
  logic [`DATA_WIDTH-1:0] src2;
  logic                   res_valid;
  exu_res_t               res;
  logic [31:0]            lcg_state = 32'hd8c;
  int                     cycles = 0;
  int                     results_seen = 0;
  int                     sent;
  int                     seen_base;
  int                     fail_base;
  int                     tests_run = 0;
  int                     tests_failed = 0;

  riscv_exu_stage u_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .pc         (pc),
    .src1       (src1),
    .src2       (src2),
    .res_valid  (res_valid),
    .res        (res)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (res_valid) begin
      results_seen <= results_seen + 1;
    end
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout, stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // register and immediate fields between funct7 and opcode are random
  function automatic logic [31:0] random_inst(input logic [6:0] f7, input logic [2:0] f3,
                                              input logic [6:0] op);
    logic [31:0] r;
    r = next_rand();
    return {f7, r[24:15], f3, r[11:7], op};
  endfunction

  task automatic drive_inst(input logic [31:0] word, input logic [31:0] a,
                            input logic [31:0] b, input int gap);
    @(negedge clk);
    inst_valid = 1'b1;
    inst       = word;
    pc         = next_rand() & ~32'd3;
    src1       = a;
    src2       = b;
    sent++;
    repeat (gap) begin
      @(negedge clk);
      inst_valid = 1'b0;
    end
  endtask

  task automatic open_test();
    sent      = 0;
    seen_base = results_seen;
    fail_base = u_dut.u_assertions.fail_count;
  endtask

  task automatic close_test(input string name);
    int seen;
    int failures;
    repeat (2) begin
      @(negedge clk);
      inst_valid = 1'b0;
    end
    seen     = results_seen - seen_base;
    failures = u_dut.u_assertions.fail_count - fail_base;
    tests_run++;
    if (seen != sent) begin
      $display("FAILED at %0t res_valid count got %0d expected %0d", $time, seen, sent);
    end
    if (seen != sent || failures != 0) begin
      tests_failed++;
      $display("test %0d %s failed: %0d strobes, %0d assertion failures", tests_run, name,
               sent, failures);
    end else begin
      $display("test %0d %s passed: %0d strobes", tests_run, name, sent);
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    logic [6:0]  f7;
    logic [2:0]  f3;
    arst_n     = 1'b0;
    inst_valid = 1'b0;
    inst       = '0;
    pc         = '0;
    src1       = '0;
    src2       = '0;

    open_test();
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    close_test("reset");

    open_test();
    for (int i = 0; i < ALU_N; i++) begin
      r  = next_rand();
      f3 = r[2:0];
      f7 = (r[3] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
      if (i % 2 == 0) begin
        drive_inst(random_inst(f7, f3, 7'h33), next_rand(), next_rand(), 1);
      end else begin
        if (f3 != 3'd1 && f3 != 3'd5) begin
          f7 = r[10:4];  // plain immediate bits
        end
        drive_inst(random_inst(f7, f3, 7'h13), next_rand(), next_rand(), 1);
      end
    end
    close_test("alu");

    open_test();
    for (int i = 0; i < BRANCH_N; i++) begin
      r  = next_rand();
      f3 = 3'(i % 6 + ((i % 6) >= 2 ? 2 : 0));
      a  = next_rand();
      b  = a;
      if (i / 6 == 1) begin
        a = a | 32'h8000_0000;  // negative against positive
        b = b & 32'h7fff_ffff;
      end else if (i / 6 == 2) begin
        a = a & 32'h7fff_ffff;
        b = b | 32'h8000_0000;
      end else if (i / 6 == 3) begin
        a = 32'hffff_ffff;
        b = b & 32'h0000_ffff;
      end
      drive_inst(random_inst(r[6:0], f3, 7'h63), a, b, 1);
    end
    close_test("branch");

    open_test();
    for (int i = 0; i < JUMP_N; i++) begin
      r = next_rand();
      drive_inst(random_inst(r[6:0], r[14:12], i % 2 == 0 ? 7'h6f : 7'h67), next_rand(),
                 next_rand(), 1);
    end
    close_test("jump");

    open_test();
    for (int i = 0; i < UPPER_N; i++) begin
      r = next_rand();
      if (i >= UPPER_N - 2) begin
        drive_inst(random_inst(r[6:0], r[14:12], 7'h03), next_rand(), next_rand(), 1);
      end else begin
        drive_inst(random_inst(r[6:0], r[14:12], i % 2 == 0 ? 7'h37 : 7'h17), next_rand(),
                   next_rand(), 1);
      end
    end
    close_test("upper immediate");

    open_test();
    for (int i = 0; i < 2 * MIX_N; i++) begin
      r = next_rand();
      drive_inst(random_inst(7'h00, r[14:12], MIX_OPS[r[1:0]]), next_rand(), next_rand(),
                 i < MIX_N ? 0 : int'(r[6:5]));
    end
    close_test("back to back");

    $display("%0d tests run, %0d failed, %0d assertion failures", tests_run, tests_failed,
             u_dut.u_assertions.fail_count);
    if (tests_failed == 0 && u_dut.u_assertions.fail_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- riscv_exu_stage.f
+incdir+common
common/riscv_pkg.sv
exu/riscv_ex_alu.sv
exu/riscv_exu.sv
logic/riscv_idu_decode.sv
logic/riscv_exu_stage.sv
verification/riscv_exu_stage_assertions.sv
verification/riscv_exu_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass message in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns --top-module riscv_exu_stage_tb \
  -f riscv_exu_stage.f > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vriscv_exu_stage_tb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "Simulation completed successfully" sim.log && echo "run passed" || {
  echo "run failed"
  exit 1
}
